//--- include/phaseTable.svh
/*
 * Phase reference table for the multi-h trellis.
 * Quantized 7*cos and 7*sin at sixteenth-turn phase steps,
 * 4-bit signed, shared by the filter bank and the bench model.
 */
`ifndef PHASE_TABLE_SVH
`define PHASE_TABLE_SVH

// one entry per sixteenth of a turn
localparam int phaseCount = 16;

// ----------------------------------------
// cosine, k = 0 .. 15
// ----------------------------------------
localparam logic signed [3:0] phaseCos [phaseCount] = '{
   7,  6,  5,  3,
   0, -3, -5, -6,
   -7, -6, -5, -3,
   0,  3,  5,  6
};

// ----------------------------------------
// sine, k = 0 .. 15
// ----------------------------------------
localparam logic signed [3:0] phaseSin [phaseCount] = '{
   0,  3,  5,  6,
   7,  6,  5,  3,
   0, -3, -5, -6,
   -7, -6, -5, -3
};

// trellis state s sits at table index 2s
// odd entries are the half-steps of h-index 0

`endif

//--- src/multiHPkg.sv
/*
 * Multi-h trellis package.
 * Widths, trellis size, modulation index type and the structs
 * that carry samples and branch metrics between the stages.
 */
`default_nettype none

package multiHPkg;

   // ----------------------------------------
   // widths and counts
   // ----------------------------------------
   // signed I or Q sample
   localparam int sampleWidth = 10;
   // carrier phase in eighths of a turn
   localparam int numStates = 8;
   localparam int stateWidth = 3;
   // signed path metric
   localparam int metricWidth = 18;
   // signed branch metric, two samples of I*cos + Q*sin
   localparam int branchWidth = 16;
   // index into the sixteenth-turn table
   localparam int phaseWidth = 4;

   `include "phaseTable.svh"

   // ----------------------------------------
   // types
   // ----------------------------------------
   // h-index 0 steps one eighth, h-index 1 steps two
   typedef enum logic {
      hIdx0 = 1'b0,
      hIdx1 = 1'b1
   } hIndexT;

   typedef struct packed {
      logic signed [sampleWidth-1:0] i;
      logic signed [sampleWidth-1:0] q;
   } iqSampleT;

   // both half-symbol samples of one symbol
   typedef struct packed {
      iqSampleT first;
      iqSampleT second;
      hIndexT   hIndex;
   } samplePairT;

   // metric[start state][bit], bit 1 moves the phase up
   typedef struct packed {
      logic [numStates-1:0][1:0][branchWidth-1:0] metric;
      hIndexT                                     hIndex;
   } branchSetT;

endpackage

`default_nettype wire

//--- src/symbolTiming.sv
/*
 * Symbol timing.
 * Pairs the two half-symbol samples of every symbol and tags
 * each pair with the alternating modulation index.
 */
`timescale 1ns/1ps
`default_nettype none

module symbolTiming (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  symEn,
   input  logic                  sym2xEn,
   input  multiHPkg::iqSampleT   sample,
   output multiHPkg::samplePairT pair,
   output logic                  pairValid
);
   import multiHPkg::*;

   iqSampleT firstHalf;
   logic     pending;
   hIndexT   hIndex;
   logic     firstStrobe;
   logic     secondStrobe;

   // symEn only counts together with sym2xEn
   assign firstStrobe  = sym2xEn && symEn;
   // orphan second half falls through here
   assign secondStrobe = sym2xEn && !symEn && pending;

   // hold first half until its partner arrives
   always_ff @(posedge clk) begin
      if (firstStrobe) begin
         firstHalf <= sample;
      end
   end

   // pair out on the edge that takes the second half
   always_ff @(posedge clk) begin
      if (secondStrobe) begin
         pair.first  <= firstHalf;
         pair.second <= sample;
         pair.hIndex <= hIndex;
      end
   end

   // ----------------------------------------
   // pending flag and index toggle
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         pending   <= 1'b0;
         hIndex    <= hIdx0;
         pairValid <= 1'b0;
      end else begin
         pairValid <= secondStrobe;
         if (firstStrobe) begin
            pending <= 1'b1;
         end else if (secondStrobe) begin
            pending <= 1'b0;
            // index alternates once per completed symbol
            hIndex  <= (hIndex == hIdx0) ? hIdx1 : hIdx0;
         end
      end
   end

endmodule

`default_nettype wire

//--- src/mfiltBank.sv
/*
 * Matched filter bank.
 * Correlates one half-symbol sample pair with the 16 ideal
 * branch waveforms (8 start states x 2 bits) of its h-index.
 */
`timescale 1ns/1ps
`default_nettype none

module mfiltBank (
   input  logic                  clk,
   input  logic                  reset,
   input  multiHPkg::samplePairT pair,
   input  logic                  pairValid,
   output multiHPkg::branchSetT  branches,
   output logic                  branchValid
);
   import multiHPkg::*;

   logic [numStates-1:0][1:0][branchWidth-1:0] metricNext;
   logic [phaseWidth-1:0] step;
   logic [phaseWidth-1:0] base;
   logic [phaseWidth-1:0] offset;
   logic [phaseWidth-1:0] idxFirst;
   logic [phaseWidth-1:0] idxSecond;

   // I*cos + Q*sin against one table entry
   function automatic logic signed [branchWidth-1:0] corr(
      input iqSampleT              s,
      input logic [phaseWidth-1:0] idx
   );
      logic signed [branchWidth-1:0] iTerm;
      logic signed [branchWidth-1:0] qTerm;
      iTerm = $signed(s.i) * phaseCos[idx];
      qTerm = $signed(s.q) * phaseSin[idx];
      return iTerm + qTerm;
   endfunction

   // ----------------------------------------
   // reference phase per hypothesis
   // ----------------------------------------
   always_comb begin
      // step in sixteenths per half symbol
      step = (pair.hIndex == hIdx1) ? phaseWidth'(2) : phaseWidth'(1);
      base = '0;
      offset = '0;
      idxFirst = '0;
      idxSecond = '0;
      for (int s = 0; s < numStates; s++) begin
         // state s starts at 2s sixteenths
         base = phaseWidth'(2 * s);
         for (int b = 0; b < 2; b++) begin
            // bit 1 up, bit 0 down
            offset = (b == 1) ? step : phaseWidth'(-step);
            // 4-bit wrap gives modulo 16
            idxFirst  = base + offset;
            idxSecond = base + (offset << 1);
            metricNext[s][b] = corr(pair.first, idxFirst)
                             + corr(pair.second, idxSecond);
         end
      end
   end

   // metrics and index go out together
   always_ff @(posedge clk) begin
      if (pairValid) begin
         branches.metric <= metricNext;
         branches.hIndex <= pair.hIndex;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         branchValid <= 1'b0;
      end else begin
         branchValid <= pairValid;
      end
   end

   // max |metric| is 4 * 511 * 7, well inside branchWidth
   // second sample lands on 2 * end state

endmodule

`default_nettype wire

//--- src/acsMultiH.sv
/*
 * Add-compare-select for the 8-state multi-h trellis.
 * Updates the path metrics, normalizes to the best one, clamps
 * at the floor and gives the one-symbol decision and best state.
 */
`timescale 1ns/1ps
`default_nettype none

module acsMultiH #(
   parameter int saturateFloor = -(2 ** (multiHPkg::metricWidth - 1)) + 1
) (
   input  logic                             clk,
   input  logic                             reset,
   input  multiHPkg::branchSetT             branches,
   input  logic                             branchValid,
   output logic                             decision,
   output logic [multiHPkg::stateWidth-1:0] bestState,
   output logic                             decisionValid
);
   import multiHPkg::*;

   // one guard bit for add and subtract
   typedef logic signed [metricWidth:0] candT;

   logic signed [metricWidth-1:0] pathMetric [numStates];
   logic signed [metricWidth-1:0] newMetric [numStates];
   candT                          survCand [numStates];
   logic [numStates-1:0]          survBit;
   candT                          bestCand;
   logic [stateWidth-1:0]         bestIdx;
   logic [stateWidth-1:0]         step;
   logic [stateWidth-1:0]         pred1;
   logic [stateWidth-1:0]         pred0;
   candT                          cand1;
   candT                          cand0;
   candT                          diff;

   // ----------------------------------------
   // add, compare, select
   // ----------------------------------------
   always_comb begin
      // phase step in eighths
      step = (branches.hIndex == hIdx1) ? stateWidth'(2) : stateWidth'(1);
      bestCand = '0;
      bestIdx = '0;
      pred1 = '0;
      pred0 = '0;
      cand1 = '0;
      cand0 = '0;
      for (int n = 0; n < numStates; n++) begin
         // bit 1 arrives from below, bit 0 from above
         pred1 = stateWidth'(n) - step;
         pred0 = stateWidth'(n) + step;
         cand1 = pathMetric[pred1] + $signed(branches.metric[pred1][1]);
         cand0 = pathMetric[pred0] + $signed(branches.metric[pred0][0]);
         // tie goes to bit 0
         if (cand1 > cand0) begin
            survCand[n] = cand1;
            survBit[n]  = 1'b1;
         end else begin
            survCand[n] = cand0;
            survBit[n]  = 1'b0;
         end
         // strict compare keeps the lowest index on a tie
         if (n == 0 || survCand[n] > bestCand) begin
            bestCand = survCand[n];
            bestIdx  = stateWidth'(n);
         end
      end
   end

   // ----------------------------------------
   // normalize and saturate
   // ----------------------------------------
   always_comb begin
      diff = '0;
      for (int n = 0; n < numStates; n++) begin
         // best state ends at zero, all others below
         diff = survCand[n] - bestCand;
         if (diff < candT'(saturateFloor)) begin
            newMetric[n] = metricWidth'(saturateFloor);
         end else begin
            newMetric[n] = diff[metricWidth-1:0];
         end
      end
   end

   // metrics start equal so no phase is preferred
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int n = 0; n < numStates; n++) begin
            pathMetric[n] <= '0;
         end
      end else if (branchValid) begin
         for (int n = 0; n < numStates; n++) begin
            pathMetric[n] <= newMetric[n];
         end
      end
   end

   // survivor bit into the best state
   always_ff @(posedge clk) begin
      if (branchValid) begin
         decision  <= survBit[bestIdx];
         bestState <= bestIdx;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         decisionValid <= 1'b0;
      end else begin
         decisionValid <= branchValid;
      end
   end

endmodule

`default_nettype wire

//--- src/trellisMultiH.sv
/*
 * Multi-h trellis core, top level.
 * Symbol timing, matched filter bank and ACS in a three-stage
 * chain from half-symbol samples to hard decisions.
 */
`timescale 1ns/1ps
`default_nettype none

module trellisMultiH #(
   parameter int saturateFloor = -(2 ** (multiHPkg::metricWidth - 1)) + 1
) (
   input  logic                                     clk,
   input  logic                                     reset,
   input  logic                                     symEn,
   input  logic                                     sym2xEn,
   input  logic signed [multiHPkg::sampleWidth-1:0] iIn,
   input  logic signed [multiHPkg::sampleWidth-1:0] qIn,
   output logic                                     decision,
   output logic [multiHPkg::stateWidth-1:0]         bestState,
   output logic                                     decisionValid
);
   import multiHPkg::*;

   iqSampleT   sampleIn;
   samplePairT pair;
   logic       pairValid;
   branchSetT  branches;
   logic       branchValid;

   assign sampleIn.i = iIn;
   assign sampleIn.q = qIn;

   // ----------------------------------------
   // stage 1, sample pairing
   // ----------------------------------------
   symbolTiming symbolTiming_i (
      .clk       (clk),
      .reset     (reset),
      .symEn     (symEn),
      .sym2xEn   (sym2xEn),
      .sample    (sampleIn),
      .pair      (pair),
      .pairValid (pairValid)
   );

   // stage 2, branch correlation
   mfiltBank mfiltBank_i (
      .clk         (clk),
      .reset       (reset),
      .pair        (pair),
      .pairValid   (pairValid),
      .branches    (branches),
      .branchValid (branchValid)
   );

   // stage 3, decision 3 clocks after the second half
   acsMultiH #(
      .saturateFloor (saturateFloor)
   ) acsMultiH_i (
      .clk           (clk),
      .reset         (reset),
      .branches      (branches),
      .branchValid   (branchValid),
      .decision      (decision),
      .bestState     (bestState),
      .decisionValid (decisionValid)
   );

endmodule

`default_nettype wire

//--- test/trellisMultiHTb.sv
/*
 * Testbench for the multi-h trellis core.
 * Directed tests against a bench model of the branch
 * correlation, add-compare-select and normalization rules.
 */
`timescale 1ns/1ps
`default_nettype none

module trellisMultiHTb;
   import multiHPkg::*;
   `include "phaseTable.svh"

   // raised floor so strong runs really clamp
   localparam int floorTb = -6000;
   localparam int waitLimit = 12;

   logic                          clk;
   logic                          reset;
   logic                          symEn;
   logic                          sym2xEn;
   logic signed [sampleWidth-1:0] iIn;
   logic signed [sampleWidth-1:0] qIn;
   logic                          decision;
   logic [stateWidth-1:0]         bestState;
   logic                          decisionValid;

   logic [31:0]           lfsr;
   int                    modelMetric [numStates];
   hIndexT                symH;
   int                    txPhase;
   logic                  satHit;
   int                    decCount;
   logic                  gotBit;
   logic [stateWidth-1:0] gotState;

   trellisMultiH #(.saturateFloor(floorTb)) dut_i (
      .clk           (clk),
      .reset         (reset),
      .symEn         (symEn),
      .sym2xEn       (sym2xEn),
      .iIn           (iIn),
      .qIn           (qIn),
      .decision      (decision),
      .bestState     (bestState),
      .decisionValid (decisionValid)
   );

   always #50 clk = ~clk;

   // every decision strobe, wanted or not
   always @(negedge clk) begin
      if (decisionValid) begin
         decCount = decCount + 1;
      end
   end

   // ----------------------------------------
   // random bits, x^32 + x^22 + x^2 + x + 1
   // ----------------------------------------
   function automatic logic lfsrBit();
      logic fb;
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic int randBits(input int n);
      int v;
      v = 0;
      for (int k = 0; k < n; k++) begin
         v = (v << 1) | int'(lfsrBit());
      end
      return v;
   endfunction

   // ----------------------------------------
   // compare tasks
   // ----------------------------------------
   task automatic compareBit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         $display("TB FAILED");
         $fatal(1, "bit mismatch");
      end
   endtask

   task automatic compareState(input logic [stateWidth-1:0] got,
                               input logic [stateWidth-1:0] exp, input string what);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
         $display("TB FAILED");
         $fatal(1, "state mismatch");
      end
   endtask

   task automatic compareCount(input int got, input int exp, input string what);
      if (got != exp) begin
         $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
         $display("TB FAILED");
         $fatal(1, "count mismatch");
      end
   endtask

   // ----------------------------------------
   // bench model
   // ----------------------------------------
   // I*cos + Q*sin at a sixteenth-turn index
   function automatic int correlate(input iqSampleT x, input int idx);
      return int'($signed(x.i)) * int'(phaseCos[idx & 15])
           + int'($signed(x.q)) * int'(phaseSin[idx & 15]);
   endfunction

   task automatic modelStep(input iqSampleT s1, input iqSampleT s2,
                            output logic expBit, output logic [stateWidth-1:0] expState);
      int   bm [numStates][2];
      int   cand [numStates];
      logic surv [numStates];
      int   m;
      int   d;
      int   p1;
      int   p0;
      int   c1;
      int   c0;
      int   best;
      int   bestN;
      int   diff;
      m = (symH == hIdx1) ? 2 : 1;
      // branch s,b ends at 2s + d*m*k sixteenths for sample k
      for (int s = 0; s < numStates; s++) begin
         for (int b = 0; b < 2; b++) begin
            d = (b == 1) ? 1 : -1;
            bm[s][b] = correlate(s1, 2 * s + d * m) + correlate(s2, 2 * s + 2 * d * m);
         end
      end
      best = 0;
      bestN = 0;
      for (int n = 0; n < numStates; n++) begin
         p1 = (n - m) & 7;
         p0 = (n + m) & 7;
         c1 = modelMetric[p1] + bm[p1][1];
         c0 = modelMetric[p0] + bm[p0][0];
         // bit 0 on equal candidates
         surv[n] = (c1 > c0);
         cand[n] = (c1 > c0) ? c1 : c0;
         if (n == 0 || cand[n] > best) begin
            best = cand[n];
            bestN = n;
         end
      end
      // normalize to the best, clamp at the floor
      for (int n = 0; n < numStates; n++) begin
         diff = cand[n] - best;
         if (diff < floorTb) begin
            modelMetric[n] = floorTb;
            satHit = 1'b1;
         end else begin
            modelMetric[n] = diff;
         end
      end
      expBit = surv[bestN];
      expState = stateWidth'(bestN);
      symH = (symH == hIdx0) ? hIdx1 : hIdx0;
   endtask

   // ----------------------------------------
   // stimulus helpers
   // ----------------------------------------
   function automatic iqSampleT makeSample(input int idx, input int scale, input logic noisy);
      iqSampleT s;
      int       ni;
      int       nq;
      ni = noisy ? randBits(6) - 32 : 0;
      nq = noisy ? randBits(6) - 32 : 0;
      s.i = sampleWidth'(scale * int'(phaseCos[idx & 15]) + ni);
      s.q = sampleWidth'(scale * int'(phaseSin[idx & 15]) + nq);
      return s;
   endfunction

   task automatic resetDut();
      @(negedge clk);
      reset = 1'b1;
      repeat (8) @(negedge clk);
      reset = 1'b0;
      for (int n = 0; n < numStates; n++) begin
         modelMetric[n] = 0;
      end
      symH = hIdx0;
      txPhase = 0;
   endtask

   // one symbol, decision checked against the model
   task automatic runSymbol(input iqSampleT s1, input iqSampleT s2);
      logic                  expBit;
      logic [stateWidth-1:0] expState;
      int                    latency;
      modelStep(s1, s2, expBit, expState);
      @(negedge clk);
      symEn = 1'b1;
      sym2xEn = 1'b1;
      iIn = s1.i;
      qIn = s1.q;
      @(negedge clk);
      symEn = 1'b0;
      sym2xEn = 1'b0;
      // second half 4 cycles after the first
      repeat (3) @(negedge clk);
      sym2xEn = 1'b1;
      iIn = s2.i;
      qIn = s2.q;
      latency = 0;
      do begin
         @(negedge clk);
         sym2xEn = 1'b0;
         latency++;
      end while (!decisionValid && latency < waitLimit);
      if (!decisionValid) begin
         $display("Timeout: no decisionValid after the second half of a symbol");
         $display("TB FAILED");
         $fatal(1, "decision timeout");
      end
      compareCount(latency, 3, "decision latency");
      compareBit(decision, expBit, "decision");
      compareState(bestState, expState, "bestState");
      gotBit = decision;
      gotState = bestState;
      // a single pulse per symbol
      @(negedge clk);
      compareBit(decisionValid, 1'b0, "decisionValid after pulse");
   endtask

   // rot shifts the sent phase in sixteenths
   task automatic sendBit(input logic b, input int scale, input int rot, input logic noisy);
      int       m;
      int       d;
      iqSampleT s1;
      iqSampleT s2;
      m = (symH == hIdx1) ? 2 : 1;
      d = b ? 1 : -1;
      s1 = makeSample(2 * txPhase + rot + d * m, scale, noisy);
      s2 = makeSample(2 * txPhase + rot + 2 * d * m, scale, noisy);
      txPhase = (txPhase + d * m) & 7;
      runSymbol(s1, s2);
   endtask

   // ----------------------------------------
   // directed tests
   // ----------------------------------------
   task automatic cleanPathTest();
      logic b;
      for (int k = 0; k < 24; k++) begin
         b = lfsrBit();
         sendBit(b, 32, 0, 1'b0);
         compareBit(gotBit, b, "decision vs sent bit");
         compareState(gotState, stateWidth'(txPhase), "bestState vs sent phase");
      end
   endtask

   // steps of 1 then 2 eighths from hIdx0
   task automatic alternateTest();
      logic [stateWidth-1:0] expState;
      resetDut();
      expState = '0;
      for (int k = 0; k < 6; k++) begin
         sendBit(1'b1, 32, 0, 1'b0);
         expState = expState + ((k % 2 == 0) ? 3'd1 : 3'd2);
         compareState(gotState, expState, "bestState step");
      end
   endtask

   task automatic noisyTest();
      for (int k = 0; k < 40; k++) begin
         sendBit(lfsrBit(), 32, 0, 1'b1);
      end
   endtask

   task automatic latencyTest();
      int start;
      start = decCount;
      for (int k = 0; k < 8; k++) begin
         sendBit(lfsrBit(), 32, 0, 1'b0);
      end
      compareCount(decCount - start, 8, "decision pulses");
   endtask

   task automatic saturationTieTest();
      iqSampleT zero;
      zero = '0;
      resetDut();
      // equal metrics everywhere
      for (int k = 0; k < 2; k++) begin
         runSymbol(zero, zero);
         compareBit(gotBit, 1'b0, "tie decision");
         compareState(gotState, 3'd0, "tie bestState");
      end
      satHit = 1'b0;
      // full-scale samples half a turn off
      for (int k = 0; k < 30; k++) begin
         sendBit(lfsrBit(), 73, 8, 1'b0);
      end
      if (!satHit) begin
         $display("Strong run never drove a metric to the floor");
         $display("TB FAILED");
         $fatal(1, "no saturation");
      end
      // phase flips half a turn, new best path starts from clamped metrics
      for (int k = 0; k < 4; k++) begin
         sendBit(lfsrBit(), 73, 0, 1'b0);
      end
   endtask

   task automatic orphanTest();
      @(negedge clk);
      sym2xEn = 1'b1;
      symEn = 1'b0;
      @(negedge clk);
      sym2xEn = 1'b0;
      for (int k = 0; k < waitLimit; k++) begin
         @(negedge clk);
         if (decisionValid) begin
            $display("A second half with no first half produced a decision");
            $display("TB FAILED");
            $fatal(1, "orphan decision");
         end
      end
      sendBit(lfsrBit(), 32, 0, 1'b0);
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      symEn = 1'b0;
      sym2xEn = 1'b0;
      iIn = '0;
      qIn = '0;
      lfsr = 32'h991b_b9b1;
      decCount = 0;
      satHit = 1'b0;
      resetDut();
      cleanPathTest();
      alternateTest();
      noisyTest();
      latencyTest();
      saturationTieTest();
      orphanTest();
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
src/multiHPkg.sv
src/symbolTiming.sv
src/mfiltBank.sv
src/acsMultiH.sv
src/trellisMultiH.sv
test/trellisMultiHTb.sv

//--- run.sh
#!/bin/sh
# Build and run the multi-h trellis testbench with Verilator.
# Exit status is nonzero if the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f \
   --top-module trellisMultiHTb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/VtrellisMultiHTb
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi

echo "Simulation finished"
exit 0
